// ==== axi_addr_data_latch.sv ====
//////////////////////////////////////////////////////////////////////
// AXI address and data latch
// Holds the request in flight, drives it onto the system bus and
// keeps the read data for the R channel
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bridge_params.svh"

module axi_addr_data_latch (
  input  logic               clk_i,
  input  logic               reset_i,
  input  logic               aw_load_i,
  input  logic               w_load_i,
  input  logic               ar_load_i,
  input  logic               bus_wen_i,
  input  logic               bus_ren_i,
  input  logic               rd_capture_i,
  input  logic [`BUS_AW-1:0] awaddr_i,
  input  logic [`BUS_AW-1:0] araddr_i,
  input  logic [`BUS_DW-1:0] wdata_i,
  input  logic [3:0]         wstrb_i,
  input  logic [`AXI_IW-1:0] awid_i,
  input  logic [`AXI_IW-1:0] arid_i,
  output logic [`BUS_DW-1:0] rdata_o,
  output logic [`AXI_IW-1:0] id_o,
  sys_bus_if.m               bus
);

  logic [`BUS_AW-1:0] addr_q;
  logic [`BUS_DW-1:0] wdata_q;
  logic [3:0]         sel_q;
  logic [`AXI_IW-1:0] id_q;
  logic [`BUS_DW-1:0] rdata_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      addr_q  <= '0;
      wdata_q <= '0;
      sel_q   <= '0;
      id_q    <= '0;
      rdata_q <= '0;
    end else begin
      if (aw_load_i) begin
        addr_q <= awaddr_i;
        id_q   <= awid_i;
      end else if (ar_load_i) begin
        addr_q <= araddr_i;
        id_q   <= arid_i;
      end
      if (w_load_i) begin
        wdata_q <= wdata_i;
        sel_q   <= wstrb_i;
      end
      if (rd_capture_i) begin
        rdata_q <= bus.rdata;
      end else if (ar_load_i) begin
        // Cleared per read so a failed one returns zero
        rdata_q <= '0;
      end
    end
  end

  assign bus.addr  = addr_q;
  assign bus.wdata = wdata_q;
  assign bus.sel   = bus_ren_i ? 4'hF : sel_q;
  assign bus.wen   = bus_wen_i;
  assign bus.ren   = bus_ren_i;

  assign rdata_o = rdata_q;
  assign id_o    = id_q;

endmodule

// ==== axi_gp_slave_fsm.sv ====
//////////////////////////////////////////////////////////////////////
// AXI GP slave transaction FSM
// Accepts one single-beat AXI request at a time, sequences the system
// bus access and returns the response once the bus answers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module axi_gp_slave_fsm (
  input  logic                    clk_i,
  input  logic                    reset_i,
  // AXI handshakes
  input  logic                    awvalid_i,
  input  logic                    wvalid_i,
  input  logic                    arvalid_i,
  input  logic                    bready_i,
  input  logic                    rready_i,
  output logic                    awready_o,
  output logic                    wready_o,
  output logic                    arready_o,
  output logic                    bvalid_o,
  output logic                    rvalid_o,
  // Latch control
  output logic                    aw_load_o,
  output logic                    w_load_o,
  output logic                    ar_load_o,
  output logic                    bus_wen_o,
  output logic                    bus_ren_o,
  output logic                    rd_capture_o,
  // Timeout timer
  output logic                    timer_start_o,
  input  logic                    timer_expired_i,
  // Response code for B and R channels
  output ps_bridge_pkg::axi_resp_e resp_o,
  sys_bus_if.mon                  bus
);

  import ps_bridge_pkg::*;

  bridge_state_e state_q;
  bridge_state_e state_d;
  bus_op_e       op_q;
  bus_op_e       op_d;
  axi_resp_e     resp_q;
  axi_resp_e     resp_d;
  axi_resp_e     bus_resp;
  logic          bus_done;

  //////////////////////////////////////////////////////////////////////
  // Handshake outputs
  //////////////////////////////////////////////////////////////////////

  assign awready_o = (state_q == IDLE) || (state_q == WR_ADDR);
  assign wready_o  = (state_q == IDLE) || (state_q == WR_DATA);

  // Any write activity in IDLE wins over a pending read
  assign arready_o = (state_q == IDLE) && !awvalid_i && !wvalid_i;

  assign aw_load_o = awvalid_i && awready_o;
  assign w_load_o  = wvalid_i  && wready_o;
  assign ar_load_o = arvalid_i && arready_o;

  assign bvalid_o = (state_q == WR_RESP);
  assign rvalid_o = (state_q == RD_RESP);
  assign resp_o   = resp_q;

  //////////////////////////////////////////////////////////////////////
  // Bus sequencing
  //////////////////////////////////////////////////////////////////////

  // Strobes last exactly one cycle, timer starts with them
  assign bus_wen_o     = (state_q == BUS_WR);
  assign bus_ren_o     = (state_q == BUS_RD);
  assign timer_start_o = bus_wen_o || bus_ren_o;

  assign bus_done = (state_q == WAIT_ACK) && (bus.ack || timer_expired_i);

  // Ack has priority over a coincident expiry
  always_comb begin
    if (bus.ack) begin
      bus_resp = bus.err ? RESP_SLVERR : RESP_OKAY;
    end else begin
      bus_resp = RESP_DECERR;
    end
  end

  // Only good read data is kept
  assign rd_capture_o = (state_q == WAIT_ACK) && (op_q == OP_READ) &&
                        bus.ack && !bus.err;

  //////////////////////////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    op_d    = op_q;
    resp_d  = resp_q;
    case (state_q)
      IDLE: begin
        if (aw_load_o && w_load_o) begin
          state_d = BUS_WR;
          op_d    = OP_WRITE;
        end else if (aw_load_o) begin
          state_d = WR_DATA;
          op_d    = OP_WRITE;
        end else if (w_load_o) begin
          state_d = WR_ADDR;
          op_d    = OP_WRITE;
        end else if (ar_load_o) begin
          state_d = BUS_RD;
          op_d    = OP_READ;
        end
      end
      WR_DATA: begin
        if (w_load_o) begin
          state_d = BUS_WR;
        end
      end
      WR_ADDR: begin
        if (aw_load_o) begin
          state_d = BUS_WR;
        end
      end
      BUS_WR,
      BUS_RD: begin
        state_d = WAIT_ACK;
      end
      WAIT_ACK: begin
        if (bus_done) begin
          state_d = (op_q == OP_WRITE) ? WR_RESP : RD_RESP;
          resp_d  = bus_resp;
        end
      end
      WR_RESP: begin
        if (bready_i) begin
          state_d = IDLE;
        end
      end
      RD_RESP: begin
        if (rready_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
      op_q    <= OP_WRITE;
      resp_q  <= RESP_OKAY;
    end else begin
      state_q <= state_d;
      op_q    <= op_d;
      resp_q  <= resp_d;
    end
  end

endmodule

// ==== bus_timeout_timer.sv ====
//////////////////////////////////////////////////////////////////////
// Bus timeout timer
// Flags a system bus access left unanswered for too many cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bridge_params.svh"

module bus_timeout_timer (
  input  logic clk_i,
  input  logic reset_i,
  input  logic start_i,
  output logic expired_o
);

  localparam int CNT_W = $clog2(`BUS_TIMEOUT_CYCLES);

  logic [CNT_W-1:0] cnt_q;
  logic             running_q;

  // Down-counter, zero reached on the last cycle of the window
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q     <= '0;
      running_q <= 1'b0;
    end else if (start_i) begin
      cnt_q     <= CNT_W'(`BUS_TIMEOUT_CYCLES - 1);
      running_q <= 1'b1;
    end else if (running_q) begin
      if (cnt_q == '0) begin
        // One pulse, then wait for the next start
        running_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  assign expired_o = running_q && (cnt_q == '0);

endmodule

// ==== ps_bridge_params.svh ====
//////////////////////////////////////////////////////////////////////
// PS bus bridge parameters
// Bus widths, register map, timing of the register bank and timeout
//////////////////////////////////////////////////////////////////////

`ifndef PS_BRIDGE_PARAMS_SVH
`define PS_BRIDGE_PARAMS_SVH

// Bus and AXI widths
`define BUS_AW 32
`define BUS_DW 32
`define AXI_IW 12

// Register map, byte offsets
`define REG_ID_OFS   32'h0000_0000
`define REG_SCR0_OFS 32'h0000_0004
`define REG_SCR1_OFS 32'h0000_0008
`define REG_SLOW_OFS 32'h0000_000C

`define BRIDGE_ID_VALUE 32'h5042_0001

// Register bank and bus timing
`define SLOW_WAIT_CYCLES   6
`define ERR_WINDOW_END     32'h0000_0100
`define BUS_TIMEOUT_CYCLES 32

`endif

// ==== ps_bridge_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// PS bus bridge types
// FSM states, bus operation and AXI response codes
//////////////////////////////////////////////////////////////////////

package ps_bridge_pkg;

  // Transaction FSM states
  typedef enum logic [2:0] {
    IDLE,
    WR_DATA,
    WR_ADDR,
    BUS_WR,
    BUS_RD,
    WAIT_ACK,
    WR_RESP,
    RD_RESP
  } bridge_state_e;

  // Operation of the access in flight
  typedef enum logic {
    OP_WRITE,
    OP_READ
  } bus_op_e;

  // AXI BRESP / RRESP encoding
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

endpackage

// ==== ps_bus_bridge.f ====
+incdir+.
ps_bridge_pkg.sv
sys_bus_if.sv
axi_gp_slave_fsm.sv
bus_timeout_timer.sv
axi_addr_data_latch.sv
sys_reg_bank.sv
ps_bus_bridge.sv
tb_ps_bus_bridge.sv

// ==== ps_bus_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// PS GP port to system bus bridge
// Single-beat AXI slave front end with a register bank behind it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bridge_params.svh"

module ps_bus_bridge (
  input  logic               clk_i,
  input  logic               reset_i,
  // Write address
  input  logic               awvalid_i,
  input  logic [`BUS_AW-1:0] awaddr_i,
  input  logic [`AXI_IW-1:0] awid_i,
  output logic               awready_o,
  // Write data
  input  logic               wvalid_i,
  input  logic [`BUS_DW-1:0] wdata_i,
  input  logic [3:0]         wstrb_i,
  output logic               wready_o,
  // Write response
  output logic               bvalid_o,
  input  logic               bready_i,
  output logic [`AXI_IW-1:0] bid_o,
  output logic [1:0]         bresp_o,
  // Read address
  input  logic               arvalid_i,
  input  logic [`BUS_AW-1:0] araddr_i,
  input  logic [`AXI_IW-1:0] arid_i,
  output logic               arready_o,
  // Read data
  output logic               rvalid_o,
  input  logic               rready_i,
  output logic [`AXI_IW-1:0] rid_o,
  output logic [`BUS_DW-1:0] rdata_o,
  output logic [1:0]         rresp_o
);

  import ps_bridge_pkg::*;

  axi_resp_e          resp;
  logic [`AXI_IW-1:0] id;
  logic               aw_load;
  logic               w_load;
  logic               ar_load;
  logic               bus_wen;
  logic               bus_ren;
  logic               rd_capture;
  logic               timer_start;
  logic               timer_expired;

  sys_bus_if sys_bus ();

  axi_gp_slave_fsm axi_gp_slave_fsm_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .awvalid_i       (awvalid_i),
    .wvalid_i        (wvalid_i),
    .arvalid_i       (arvalid_i),
    .bready_i        (bready_i),
    .rready_i        (rready_i),
    .awready_o       (awready_o),
    .wready_o        (wready_o),
    .arready_o       (arready_o),
    .bvalid_o        (bvalid_o),
    .rvalid_o        (rvalid_o),
    .aw_load_o       (aw_load),
    .w_load_o        (w_load),
    .ar_load_o       (ar_load),
    .bus_wen_o       (bus_wen),
    .bus_ren_o       (bus_ren),
    .rd_capture_o    (rd_capture),
    .timer_start_o   (timer_start),
    .timer_expired_i (timer_expired),
    .resp_o          (resp),
    .bus             (sys_bus)
  );

  bus_timeout_timer bus_timeout_timer_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (timer_start),
    .expired_o (timer_expired)
  );

  axi_addr_data_latch axi_addr_data_latch_i (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .aw_load_i    (aw_load),
    .w_load_i     (w_load),
    .ar_load_i    (ar_load),
    .bus_wen_i    (bus_wen),
    .bus_ren_i    (bus_ren),
    .rd_capture_i (rd_capture),
    .awaddr_i     (awaddr_i),
    .araddr_i     (araddr_i),
    .wdata_i      (wdata_i),
    .wstrb_i      (wstrb_i),
    .awid_i       (awid_i),
    .arid_i       (arid_i),
    .rdata_o      (rdata_o),
    .id_o         (id),
    .bus          (sys_bus)
  );

  sys_reg_bank sys_reg_bank_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .bus     (sys_bus)
  );

  // Both response channels share ID and code
  assign bid_o   = id;
  assign rid_o   = id;
  assign bresp_o = resp;
  assign rresp_o = resp;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the PS bus bridge testbench with Verilator, run it, check the log
rm -f build.log sim.log
verilator --binary -j 0 --top-module tb_ps_bus_bridge -f ps_bus_bridge.f -o tb_sim \
  > build.log 2>&1 || { echo "Build failed, see build.log"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1
grep -F -q "*** TEST PASSED ***" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed, see sim.log"; exit 1; }

// ==== sys_bus_if.sv ====
//////////////////////////////////////////////////////////////////////
// System bus interface
// Single outstanding access, one-cycle strobes and acknowledge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bridge_params.svh"

interface sys_bus_if;

  // Request side
  logic [`BUS_AW-1:0] addr;
  logic [`BUS_DW-1:0] wdata;
  logic [3:0]         sel;
  logic               wen;
  logic               ren;

  // Response side, err only meaningful with ack
  logic [`BUS_DW-1:0] rdata;
  logic               ack;
  logic               err;

  modport m (
    output addr,
    output wdata,
    output sel,
    output wen,
    output ren,
    input  rdata,
    input  ack,
    input  err
  );

  modport s (
    input  addr,
    input  wdata,
    input  sel,
    input  wen,
    input  ren,
    output rdata,
    output ack,
    output err
  );

  modport mon (
    input ack,
    input err
  );

endinterface

// ==== sys_reg_bank.sv ====
//////////////////////////////////////////////////////////////////////
// System bus register bank
// ID, two scratch registers and a slow register, with an error
// window above them and no answer beyond it
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bridge_params.svh"

module sys_reg_bank (
  input  logic clk_i,
  input  logic reset_i,
  sys_bus_if.s bus
);

  localparam int SLOW_CW = $clog2(`SLOW_WAIT_CYCLES + 1);

  logic [`BUS_DW-1:0] scr0_q;
  logic [`BUS_DW-1:0] scr1_q;
  logic [`BUS_DW-1:0] slow_q;
  logic [`BUS_DW-1:0] rdata_q;
  logic               ack_q;
  logic               err_q;
  logic               slow_busy_q;
  logic [SLOW_CW-1:0] slow_cnt_q;
  logic               strobe;
  logic               in_err_window;

  // Byte merge of write data by select
  function automatic logic [`BUS_DW-1:0] merge_bytes(
    input logic [`BUS_DW-1:0] old_val,
    input logic [`BUS_DW-1:0] new_val,
    input logic [3:0]         sel
  );
    logic [`BUS_DW-1:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign strobe        = bus.wen || bus.ren;
  assign in_err_window = (bus.addr > `REG_SLOW_OFS) && (bus.addr < `ERR_WINDOW_END);

  //////////////////////////////////////////////////////////////////////
  // Decode and registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      scr0_q      <= '0;
      scr1_q      <= '0;
      slow_q      <= '0;
      ack_q       <= 1'b0;
      err_q       <= 1'b0;
      slow_busy_q <= 1'b0;
      slow_cnt_q  <= '0;
    end else begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
      if (strobe) begin
        case (bus.addr)
          `REG_ID_OFS: begin
            // Writes here are dropped but still answered
            ack_q <= 1'b1;
          end
          `REG_SCR0_OFS: begin
            ack_q <= 1'b1;
            if (bus.wen) begin
              scr0_q <= merge_bytes(scr0_q, bus.wdata, bus.sel);
            end
          end
          `REG_SCR1_OFS: begin
            ack_q <= 1'b1;
            if (bus.wen) begin
              scr1_q <= merge_bytes(scr1_q, bus.wdata, bus.sel);
            end
          end
          `REG_SLOW_OFS: begin
            slow_busy_q <= 1'b1;
            slow_cnt_q  <= SLOW_CW'(`SLOW_WAIT_CYCLES - 1);
            if (bus.wen) begin
              slow_q <= merge_bytes(slow_q, bus.wdata, bus.sel);
            end
          end
          default: begin
            // Unmapped above the window, never acknowledged
            if (in_err_window) begin
              ack_q <= 1'b1;
              err_q <= 1'b1;
            end
          end
        endcase
      end else if (slow_busy_q) begin
        if (slow_cnt_q == '0) begin
          slow_busy_q <= 1'b0;
          ack_q       <= 1'b1;
        end else begin
          slow_cnt_q <= slow_cnt_q - 1'b1;
        end
      end
    end
  end

  // Read data, valid together with ack
  always_ff @(posedge clk_i) begin
    if (strobe && bus.ren) begin
      case (bus.addr)
        `REG_ID_OFS:   rdata_q <= `BRIDGE_ID_VALUE;
        `REG_SCR0_OFS: rdata_q <= scr0_q;
        `REG_SCR1_OFS: rdata_q <= scr1_q;
        default:       rdata_q <= '0;
      endcase
    end else if (slow_busy_q && (slow_cnt_q == '0)) begin
      rdata_q <= slow_q;
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.ack   = ack_q;
  assign bus.err   = err_q;

endmodule

// ==== tb_ps_bus_bridge.sv ====
//////////////////////////////////////////////////////////////////////
// PS bus bridge testbench
// Directed AXI writes and reads against a register model
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "ps_bridge_params.svh"

module tb_ps_bus_bridge;

  import ps_bridge_pkg::*;

  localparam int CLK_HALF        = 2;
  localparam int NUM_TXNS        = 61;
  localparam int HS_LIMIT        = `BUS_TIMEOUT_CYCLES + 20;
  localparam int WATCHDOG_CYCLES = NUM_TXNS * (`BUS_TIMEOUT_CYCLES + 20);

  // Write channel ordering
  localparam int AW_FIRST = 0;
  localparam int W_FIRST  = 1;
  localparam int BOTH     = 2;

  logic               clk_i;
  logic               reset_i;
  logic               awvalid_i;
  logic [`BUS_AW-1:0] awaddr_i;
  logic [`AXI_IW-1:0] awid_i;
  logic               awready_o;
  logic               wvalid_i;
  logic [`BUS_DW-1:0] wdata_i;
  logic [3:0]         wstrb_i;
  logic               wready_o;
  logic               bvalid_o;
  logic               bready_i;
  logic [`AXI_IW-1:0] bid_o;
  logic [1:0]         bresp_o;
  logic               arvalid_i;
  logic [`BUS_AW-1:0] araddr_i;
  logic [`AXI_IW-1:0] arid_i;
  logic               arready_o;
  logic               rvalid_o;
  logic               rready_i;
  logic [`AXI_IW-1:0] rid_o;
  logic [`BUS_DW-1:0] rdata_o;
  logic [1:0]         rresp_o;

  // Model of the four mapped words indexed by word offset
  logic [`BUS_DW-1:0] model_regs [0:3];
  integer             seed;
  int                 check_count;
  int                 error_count;
  int                 timeout_count;

  ps_bus_bridge ps_bus_bridge_i (.*);

  always #CLK_HALF clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Expected values
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] strobe_merge(input logic [31:0] old_val,
                                               input logic [31:0] new_val,
                                               input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic logic [1:0] resp_for_addr(input logic [31:0] addr);
    if (addr < 32'h10) begin
      return 2'b00;
    end else if (addr < `ERR_WINDOW_END) begin
      return 2'b10;
    end
    return 2'b11;
  endfunction

  function automatic logic [31:0] read_expect(input logic [31:0] addr);
    if (addr < 32'h10) begin
      return model_regs[addr[3:2]];
    end
    return 32'h0;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    check_count++;
    if (actual !== expected) begin
      $display("CHECK FAILED at %0t ns: %s (got %h, expected %h)",
               $time, msg, actual, expected);
      error_count++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // AXI transaction tasks that start and end 1 ns after a rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic wait_response(input bit is_read, input int ready_delay, output bit ok,
                               output logic [1:0] resp, output logic [11:0] id,
                               output logic [31:0] data);
    int cnt;
    cnt = 0;
    ok  = 1'b0;
    while (!ok && cnt < HS_LIMIT) begin
      @(negedge clk_i);
      ok = is_read ? rvalid_o : bvalid_o;
      cnt++;
    end
    resp = is_read ? rresp_o : bresp_o;
    id   = is_read ? rid_o : bid_o;
    data = rdata_o;
    if (!ok) begin
      $display("ERROR at %0t ns: no %s response arrived within %0d cycles",
               $time, is_read ? "read" : "write", HS_LIMIT);
      timeout_count++;
    end else begin
      // Hold ready low and watch the response sit still
      for (int d = 0; d < ready_delay; d++) begin
        @(negedge clk_i);
        check_value(32'(is_read ? rvalid_o : bvalid_o), 32'h1, "valid held under back-pressure");
        check_value(32'(is_read ? rresp_o : bresp_o), 32'(resp), "response code stable");
        check_value(32'(is_read ? rid_o : bid_o), 32'(id), "response ID stable");
        if (is_read) begin
          check_value(rdata_o, data, "read data stable");
        end
        check_value(32'({awready_o, wready_o, arready_o}), 32'h0,
                    "readies low while response waits");
      end
      @(posedge clk_i);
      #1;
      rready_i = is_read;
      bready_i = !is_read;
    end
    @(posedge clk_i);
    #1;
    rready_i = 1'b0;
    bready_i = 1'b0;
  endtask

  task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [11:0] id,
                           input int order, input int bready_delay);
    bit          aw_left;
    bit          w_left;
    bit          aw_hs;
    bit          w_hs;
    bit          ok;
    int          cnt;
    logic [1:0]  resp;
    logic [11:0] rsp_id;
    logic [31:0] rsp_data;
    awaddr_i  = addr;
    awid_i    = id;
    wdata_i   = data;
    wstrb_i   = strb;
    awvalid_i = (order != W_FIRST);
    wvalid_i  = (order != AW_FIRST);
    aw_left   = 1'b1;
    w_left    = 1'b1;
    cnt       = 0;
    while ((aw_left || w_left) && cnt < HS_LIMIT) begin
      @(negedge clk_i);
      aw_hs = awvalid_i && awready_o;
      w_hs  = wvalid_i && wready_o;
      @(posedge clk_i);
      #1;
      if (aw_hs) begin
        awvalid_i = 1'b0;
        aw_left   = 1'b0;
      end
      if (w_hs) begin
        wvalid_i = 1'b0;
        w_left   = 1'b0;
      end
      // Second channel follows once the first is taken
      wvalid_i  = wvalid_i || (!aw_left && w_left);
      awvalid_i = awvalid_i || (!w_left && aw_left);
      cnt++;
    end
    if (aw_left || w_left) begin
      $display("ERROR at %0t ns: write to %h was not accepted", $time, addr);
      timeout_count++;
      awvalid_i = 1'b0;
      wvalid_i  = 1'b0;
    end else begin
      wait_response(1'b0, bready_delay, ok, resp, rsp_id, rsp_data);
      if (ok) begin
        check_value(32'(resp), 32'(resp_for_addr(addr)), $sformatf("bresp of write to %h", addr));
        check_value(32'(rsp_id), 32'(id), "bid matches awid");
      end
      if (addr >= `REG_SCR0_OFS && addr <= `REG_SLOW_OFS) begin
        model_regs[addr[3:2]] = strobe_merge(model_regs[addr[3:2]], data, strb);
      end
    end
  endtask

  task automatic axi_read(input logic [31:0] addr, input logic [11:0] id,
                          input int rready_delay);
    bit          hs;
    bit          ok;
    int          cnt;
    logic [1:0]  resp;
    logic [11:0] rsp_id;
    logic [31:0] rsp_data;
    araddr_i  = addr;
    arid_i    = id;
    arvalid_i = 1'b1;
    hs        = 1'b0;
    cnt       = 0;
    while (!hs && cnt < HS_LIMIT) begin
      @(negedge clk_i);
      hs = arready_o;
      @(posedge clk_i);
      #1;
      cnt++;
    end
    arvalid_i = 1'b0;
    if (!hs) begin
      $display("ERROR at %0t ns: read of %h was not accepted", $time, addr);
      timeout_count++;
    end else begin
      wait_response(1'b1, rready_delay, ok, resp, rsp_id, rsp_data);
      if (ok) begin
        check_value(32'(resp), 32'(resp_for_addr(addr)), $sformatf("rresp of read from %h", addr));
        check_value(32'(rsp_id), 32'(id), "rid matches arid");
        check_value(rsp_data, read_expect(addr), $sformatf("rdata from %h", addr));
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic test_reset_state();
    @(negedge clk_i);
    check_value(32'({awready_o, wready_o, arready_o}), 32'h7, "readies high after reset");
    check_value(32'({bvalid_o, rvalid_o}), 32'h0, "valids low after reset");
    @(posedge clk_i);
    #1;
    axi_read(`REG_ID_OFS, 12'h123, 0);
  endtask

  task automatic test_scratch_writes();
    axi_write(`REG_SCR0_OFS, 32'hA5A5_1234, 4'hF, 12'h011, AW_FIRST, 0);
    axi_write(`REG_SCR1_OFS, 32'hDEAD_BEEF, 4'hF, 12'h012, W_FIRST, 1);
    axi_write(`REG_SCR0_OFS, 32'h7788_99AA, 4'b0110, 12'h013, BOTH, 0);
    axi_write(`REG_SCR1_OFS, 32'h0102_0304, 4'b1001, 12'h014, W_FIRST, 0);
    axi_write(`REG_SCR0_OFS, 32'hFFEE_DDCC, 4'b0001, 12'h015, AW_FIRST, 2);
    // ID register takes the write with OKAY and keeps its value
    axi_write(`REG_ID_OFS, 32'h1111_2222, 4'hF, 12'h016, BOTH, 0);
    axi_read(`REG_SCR0_OFS, 12'h021, 0);
    axi_read(`REG_SCR1_OFS, 12'h022, 1);
    axi_read(`REG_ID_OFS, 12'h023, 0);
  endtask

  task automatic test_back_pressure();
    axi_write(`REG_SCR1_OFS, 32'h3C3C_5A5A, 4'hF, 12'hABC, BOTH, 6);
    axi_read(`REG_SCR1_OFS, 12'hDEF, 7);
  endtask

  task automatic test_slow_register();
    axi_write(`REG_SLOW_OFS, 32'hCAFE_F00D, 4'hF, 12'h301, AW_FIRST, 0);
    axi_read(`REG_SLOW_OFS, 12'h302, 0);
    axi_write(`REG_SLOW_OFS, 32'h1234_5678, 4'b1100, 12'h303, W_FIRST, 3);
    axi_read(`REG_SLOW_OFS, 12'h304, 2);
  endtask

  task automatic test_error_decode();
    axi_read(32'h0000_0010, 12'h401, 0);
    axi_write(32'h0000_00F0, 32'h5555_AAAA, 4'hF, 12'h402, BOTH, 1);
    axi_read(`ERR_WINDOW_END, 12'h403, 2);
    axi_write(32'h0000_0200, 32'h6666_7777, 4'hF, 12'h404, AW_FIRST, 0);
    axi_read(`REG_SCR0_OFS, 12'h405, 0);
  endtask

  task automatic test_random_scratch();
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0]  strb;
    int          order;
    for (int i = 0; i < 20; i++) begin
      addr  = ($random(seed) & 1) ? `REG_SCR1_OFS : `REG_SCR0_OFS;
      data  = $random(seed);
      strb  = 4'($random(seed));
      order = int'({$random(seed)} % 3);
      axi_write(addr, data, strb, 12'(i), order, int'({$random(seed)} % 5));
      axi_read(addr, 12'(i + 12'h800), int'({$random(seed)} % 5));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed          = 63;
    check_count   = 0;
    error_count   = 0;
    timeout_count = 0;
    clk_i         = 1'b0;
    reset_i       = 1'b1;
    awvalid_i     = 1'b0;
    awaddr_i      = '0;
    awid_i        = '0;
    wvalid_i      = 1'b0;
    wdata_i       = '0;
    wstrb_i       = '0;
    bready_i      = 1'b0;
    arvalid_i     = 1'b0;
    araddr_i      = '0;
    arid_i        = '0;
    rready_i      = 1'b0;
    model_regs[0] = `BRIDGE_ID_VALUE;
    model_regs[1] = '0;
    model_regs[2] = '0;
    model_regs[3] = '0;
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    test_reset_state();
    test_scratch_writes();
    test_back_pressure();
    test_slow_register();
    test_error_decode();
    test_random_scratch();
    $display("Checks run: %0d, errors: %0d, timeouts: %0d",
             check_count, error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("ERROR: simulation hung, watchdog expired after %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule
